// File: fis_rx_pkg.sv
`default_nettype none

package fis_rx_pkg;

    typedef logic [31:0] dword_t;      // one fifo or register word
    typedef logic [1:0]  data_type_t;  // tag that travels with each fifo word
    typedef logic [3:0]  fis_cnt_t;    // dwords left in a counted fis
    typedef logic [11:0] dw_count_t;   // payload dwords handed to dma

    localparam data_type_t DATA_TYPE_DMA      = 2'd0; // payload dword
    localparam data_type_t DATA_TYPE_FIS_HEAD = 2'd1; // first dword of a fis
    localparam data_type_t DATA_TYPE_OK       = 2'd2; // end of fis with good crc
    localparam data_type_t DATA_TYPE_ERR      = 2'd3; // end of fis with bad crc

    // fis lengths in dwords minus one
    localparam fis_cnt_t DSFIS_LENM1  = 4'd6;  // dma setup
    localparam fis_cnt_t PSFIS_LENM1  = 4'd4;  // pio setup
    localparam fis_cnt_t RFIS_LENM1   = 4'd4;  // d2h register and signature
    localparam fis_cnt_t SDBFIS_LENM1 = 4'd1;  // set device bits
    localparam fis_cnt_t UFIS_LENM1   = 4'd15; // unknown fis
    localparam fis_cnt_t DMAH_LENM1   = 4'd0;  // data fis header only
    localparam fis_cnt_t IGNORE_LENM1 = 4'd15; // longest fis that can be dropped

    typedef struct packed {
        logic sig;      // take signature from a d2h fis
        logic dsfis;
        logic psfis;
        logic rfis;
        logic sdbfis;
        logic ufis;
        logic data_fis; // header then payload to dma
        logic ignore;
    } fis_sel_t;

    typedef struct packed {
        logic [7:0] err;
        logic [7:0] sts;
    } tfd_t;

    typedef struct packed {
        dword_t     data;
        data_type_t dtype;
        logic       valid; // at least one word in the fifo
        logic       many;  // more than one word in the fifo
    } fifo_in_t;

endpackage

`default_nettype wire

// File: hba_regs_pkg.sv
`default_nettype none

package hba_regs_pkg;

    typedef logic [9:0] reg_addr_t; // dword address into the register space

    typedef struct packed {
        logic        we;
        reg_addr_t   addr;
        logic [31:0] data;
    } reg_wr_t;

    localparam reg_addr_t PXTFD_ADDR = 10'h048; // port 0 task file data
    localparam reg_addr_t PXSIG_ADDR = 10'h049; // port 0 signature
    localparam reg_addr_t FB_ADDR    = 10'h300; // received fis area base

    // slots inside the received fis area
    localparam reg_addr_t DSFIS_OFFS  = 10'h000;
    localparam reg_addr_t PSFIS_OFFS  = 10'h008;
    localparam reg_addr_t RFIS_OFFS   = 10'h010;
    localparam reg_addr_t SDBFIS_OFFS = 10'h016;
    localparam reg_addr_t UFIS_OFFS   = 10'h018;

endpackage

`default_nettype wire

// File: fis_rx_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module fis_rx_ctrl
    import fis_rx_pkg::*;
    import hba_regs_pkg::*;
(
    input  wire logic     mclk,
    input  wire logic     hba_rst,
    input  wire fifo_in_t fifo_in,
    input  wire fis_sel_t get,             // one-hot get strobe
    input  wire logic     dma_pop,         // dma side takes the current word
    input  wire logic     dwords_over_dma, // data fis too long
    output logic          hba_data_in_ready,
    output logic          word_avail,      // word may be popped this cycle
    output logic          data_start,      // data fis header popped
    output logic          store,           // current word goes to the fis area
    output reg_addr_t     store_addr,
    output logic          sig_hi,          // signature dword 1 popped
    output logic          sig_lo,          // signature dword 3 popped
    output logic          d2h_load,
    output logic          sdb_load,
    output logic          fis_first_vld,
    output logic          get_fis_busy,
    output logic          get_fis_done,
    output logic          fis_ok,
    output logic          fis_err,
    output logic          fis_ferr
);

    logic       get_any;   // any get strobe this cycle
    logic [1:0] was_pop;   // pops in the last two cycles
    logic       fis_end;   // end tag at the fifo output
    logic       wr_word;   // pop of a counted fis dword
    logic       end_pop;   // pop of the end word
    logic       overrun;   // dword beyond the fis length
    logic       ferr_set;
    reg_addr_t  sel_addr;  // slot of the selected fis
    fis_cnt_t   sel_len;   // length of the selected fis
    reg_addr_t  addr_r;
    fis_cnt_t   dcount;    // dwords left minus one
    logic       dw_done;   // all counted dwords popped
    logic [3:0] word_sr;   // one-hot dword position 0..3
    logic       save_r;    // fis goes into the register space
    logic       is_data_r;
    logic       is_rfis_r;
    logic       is_sdb_r;
    logic       is_sig_r;

    assign get_any = |get;
    assign fis_end = (fifo_in.dtype == DATA_TYPE_OK) || (fifo_in.dtype == DATA_TYPE_ERR);

    // single word left needs two quiet cycles before the next pop
    assign word_avail = fifo_in.valid && !fis_ferr && (fifo_in.many || !(|was_pop));

    assign wr_word  = get_fis_busy && word_avail && !fis_end && !dw_done;
    assign end_pop  = get_fis_busy && word_avail && fis_end;
    assign overrun  = get_fis_busy && word_avail && !fis_end && dw_done && !is_data_r;
    assign ferr_set = overrun || dwords_over_dma;

    assign hba_data_in_ready = dma_pop || wr_word || end_pop;

    assign store      = wr_word && save_r;
    assign store_addr = addr_r;
    assign data_start = wr_word && is_data_r;
    assign d2h_load   = wr_word && word_sr[0] && (is_rfis_r || is_sig_r); // dword 0
    assign sdb_load   = wr_word && word_sr[0] && is_sdb_r;
    assign sig_hi     = wr_word && word_sr[1] && is_sig_r;
    assign sig_lo     = wr_word && word_sr[3] && is_sig_r;

    assign sel_addr = ({10{get.dsfis}}  & (FB_ADDR + DSFIS_OFFS))  |
                      ({10{get.psfis}}  & (FB_ADDR + PSFIS_OFFS))  |
                      ({10{get.rfis}}   & (FB_ADDR + RFIS_OFFS))   |
                      ({10{get.sdbfis}} & (FB_ADDR + SDBFIS_OFFS)) |
                      ({10{get.ufis}}   & (FB_ADDR + UFIS_OFFS));

    assign sel_len = ({4{get.sig}}      & RFIS_LENM1)   |
                     ({4{get.dsfis}}    & DSFIS_LENM1)  |
                     ({4{get.psfis}}    & PSFIS_LENM1)  |
                     ({4{get.rfis}}     & RFIS_LENM1)   |
                     ({4{get.sdbfis}}   & SDBFIS_LENM1) |
                     ({4{get.ufis}}     & UFIS_LENM1)   |
                     ({4{get.data_fis}} & DMAH_LENM1)   |
                     ({4{get.ignore}}   & IGNORE_LENM1);

    always_ff @(posedge mclk) begin
        if (get_any) begin
            addr_r <= sel_addr;         // first slot of the fis
        end else if (store) begin
            addr_r <= addr_r + 1'b1;    // walk to the next dword
        end
    end

    always_ff @(posedge mclk) begin
        if (hba_rst) begin
            dcount    <= '0;
            dw_done   <= 1'b0;
            word_sr   <= '0;
            save_r    <= 1'b0;
            is_data_r <= 1'b0;
            is_rfis_r <= 1'b0;
            is_sdb_r  <= 1'b0;
            is_sig_r  <= 1'b0;
        end else if (get_any) begin
            dcount    <= sel_len;
            dw_done   <= 1'b0;
            word_sr   <= 4'b0001;
            save_r    <= !(get.sig || get.data_fis || get.ignore);
            is_data_r <= get.data_fis;
            is_rfis_r <= get.rfis;
            is_sdb_r  <= get.sdbfis;
            is_sig_r  <= get.sig;
        end else if (wr_word) begin
            dcount  <= dcount - 1'b1;   // wraps after the last dword, dw_done masks it
            dw_done <= (dcount == '0);
            word_sr <= word_sr << 1;
        end
    end

    always_ff @(posedge mclk) begin
        if (hba_rst) begin
            was_pop       <= '0;
            get_fis_busy  <= 1'b0;
            get_fis_done  <= 1'b0;
            fis_first_vld <= 1'b0;
            fis_ok        <= 1'b0;
            fis_err       <= 1'b0;
            fis_ferr      <= 1'b0;
        end else begin
            was_pop      <= {was_pop[0], hba_data_in_ready};
            get_fis_done <= end_pop || (get_fis_busy && ferr_set);
            if (ferr_set) begin
                fis_ferr <= 1'b1;       // sticky until reset
            end
            if (get_any) begin
                get_fis_busy <= 1'b1;
            end else if (end_pop || ferr_set) begin
                get_fis_busy <= 1'b0;
            end
            if (get_any) begin
                fis_first_vld <= 1'b0;
            end else if (!get_fis_busy && word_avail &&
                         (fifo_in.dtype == DATA_TYPE_FIS_HEAD)) begin
                fis_first_vld <= 1'b1;  // head waits for a get strobe
            end
            if (get_any) begin
                fis_ok  <= 1'b0;
                fis_err <= 1'b0;
            end else if (end_pop) begin
                fis_ok  <= (fifo_in.dtype == DATA_TYPE_OK);
                fis_err <= (fifo_in.dtype == DATA_TYPE_ERR);
            end
        end
    end

endmodule

`default_nettype wire

// File: fis_dma_fwd.sv
`timescale 1ns/1ps
`default_nettype none

module fis_dma_fwd
    import fis_rx_pkg::*;
(
    input  wire logic     mclk,
    input  wire logic     hba_rst,
    input  wire fifo_in_t fifo_in,
    input  wire logic     word_avail,      // already masked by fatal error
    input  wire logic     data_start,
    input  wire logic     dma_in_ready,
    output logic          dma_in_valid,
    output logic          dwords_over_dma,
    output dw_count_t     data_in_dwords
);

    logic      data_phase; // between data fis header and its end word
    logic      dma_stop;
    dw_count_t dw_cnt;

    assign dma_in_valid = data_phase && dma_in_ready && word_avail &&
                          (fifo_in.dtype == DATA_TYPE_DMA);
    assign dma_stop     = data_phase && word_avail && (fifo_in.dtype != DATA_TYPE_DMA);

    assign dwords_over_dma = dma_in_valid && dw_cnt[11]; // past 2048 dwords
    assign data_in_dwords  = dw_cnt;

    always_ff @(posedge mclk) begin
        if (hba_rst) begin
            data_phase <= 1'b0;
            dw_cnt     <= '0;
        end else begin
            if (dma_stop) begin
                data_phase <= 1'b0;     // first non-data word ends payload
            end else if (data_start) begin
                data_phase <= 1'b1;
            end
            if (data_start) begin
                dw_cnt <= '0;
            end else if (dma_in_valid) begin
                dw_cnt <= dw_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: tfd_status.sv
`timescale 1ns/1ps
`default_nettype none

module tfd_status
    import fis_rx_pkg::*;
(
    input  wire logic     mclk,
    input  wire logic     hba_rst,
    input  wire fifo_in_t fifo_in,
    input  wire logic     d2h_load,       // d2h or signature dword 0
    input  wire logic     sdb_load,       // set device bits dword 0
    input  wire logic     update_err_sts, // write back without change
    input  wire logic     clear_bsy_drq,
    input  wire logic     set_bsy,
    input  wire logic     set_sts_7f,
    input  wire logic     set_sts_80,
    output tfd_t          tfd,
    output logic          tfd_wb,         // pxtfd write next cycle
    output logic          fis_i,
    output logic          sdb_n
);

    logic cmd; // any status command

    assign cmd = clear_bsy_drq || set_bsy || set_sts_7f || set_sts_80;

    always_ff @(posedge mclk) begin
        if (hba_rst) begin
            tfd    <= '0;
            tfd_wb <= 1'b0;
            fis_i  <= 1'b0;
            sdb_n  <= 1'b0;
        end else begin
            tfd_wb <= cmd || update_err_sts;
            if (d2h_load) begin
                tfd   <= fifo_in.data[15:0];    // err in the upper byte
                fis_i <= fifo_in.data[14];
            end else if (sdb_load) begin
                tfd.err <= fifo_in.data[15:8];
                tfd.sts <= {tfd.sts[7], fifo_in.data[6:4], tfd.sts[3], fifo_in.data[2:0]};
                fis_i   <= fifo_in.data[14];
                sdb_n   <= fifo_in.data[15];
            end else if (clear_bsy_drq || set_bsy) begin
                // bsy is bit 7 and drq is bit 3
                tfd.sts <= (tfd.sts & ~{clear_bsy_drq, 3'b000, clear_bsy_drq, 3'b000}) |
                           {set_bsy, 7'b0};
            end else if (set_sts_7f || set_sts_80) begin
                tfd.sts <= {set_sts_80, {7{set_sts_7f}}}; // both give 0xff
            end
        end
    end

endmodule

`default_nettype wire

// File: hba_reg_wr.sv
`timescale 1ns/1ps
`default_nettype none

module hba_reg_wr
    import fis_rx_pkg::*;
    import hba_regs_pkg::*;
(
    input  wire logic      mclk,
    input  wire logic      hba_rst,
    input  wire fifo_in_t  fifo_in,
    input  wire logic      store,      // fifo word goes to store_addr
    input  wire reg_addr_t store_addr,
    input  wire logic      sig_hi,     // dword 1 of signature fis at fifo output
    input  wire logic      sig_lo,     // dword 3 of signature fis at fifo output
    input  wire tfd_t      tfd,
    input  wire logic      tfd_wb,
    output reg_wr_t        reg_wr
);

    logic [23:0] sig_hold; // lba and sector count from dword 1
    logic        we_r;
    reg_addr_t   addr_r;
    dword_t      data_r;

    assign reg_wr = '{we: we_r, addr: addr_r, data: data_r};

    always_ff @(posedge mclk) begin
        if (sig_hi) begin
            sig_hold <= fifo_in.data[23:0];
        end
    end

    always_ff @(posedge mclk) begin
        if (hba_rst) begin
            we_r <= 1'b0;
        end else begin
            we_r <= store || sig_lo || tfd_wb;
        end
    end

    // stored fis word wins over signature and pxtfd
    always_ff @(posedge mclk) begin
        if (store) begin
            addr_r <= store_addr;
            data_r <= fifo_in.data;
        end else if (sig_lo) begin
            addr_r <= PXSIG_ADDR;
            data_r <= {sig_hold, fifo_in.data[7:0]};
        end else if (tfd_wb) begin
            addr_r <= PXTFD_ADDR;
            data_r <= {16'h0000, tfd.err, tfd.sts};
        end
    end

endmodule

`default_nettype wire

// File: fis_receive.sv
`timescale 1ns/1ps
`default_nettype none

module fis_receive
    import fis_rx_pkg::*;
    import hba_regs_pkg::*;
(
    input  wire logic     mclk,
    input  wire logic     hba_rst,
    input  wire fifo_in_t fifo_in,           // transport fifo output
    output logic          hba_data_in_ready, // pops the current word
    input  wire fis_sel_t get,
    output logic          fis_first_vld,
    output logic          get_fis_busy,
    output logic          get_fis_done,
    output logic          fis_ok,
    output logic          fis_err,
    output logic          fis_ferr,
    input  wire logic     update_err_sts,
    input  wire logic     clear_bsy_drq,
    input  wire logic     set_bsy,
    input  wire logic     set_sts_7f,
    input  wire logic     set_sts_80,
    output tfd_t          tfd,
    output logic          fis_i,
    output logic          sdb_n,
    output dw_count_t     data_in_dwords,
    input  wire logic     dma_in_ready,
    output logic          dma_in_valid,
    output reg_wr_t       reg_wr
);

    logic      word_avail;
    logic      data_start;
    logic      dwords_over_dma;
    logic      store;
    reg_addr_t store_addr;
    logic      sig_hi;
    logic      sig_lo;
    logic      d2h_load;
    logic      sdb_load;
    logic      tfd_wb;

    fis_rx_ctrl u_ctrl (
        .mclk, .hba_rst, .fifo_in, .get,
        .dma_pop (dma_in_valid),       // dma pops share the fifo ready
        .dwords_over_dma, .hba_data_in_ready, .word_avail, .data_start,
        .store, .store_addr, .sig_hi, .sig_lo, .d2h_load, .sdb_load,
        .fis_first_vld, .get_fis_busy, .get_fis_done, .fis_ok, .fis_err, .fis_ferr
    );

    fis_dma_fwd u_dma_fwd (
        .mclk, .hba_rst, .fifo_in, .word_avail, .data_start, .dma_in_ready,
        .dma_in_valid, .dwords_over_dma, .data_in_dwords
    );

    tfd_status u_tfd (
        .mclk, .hba_rst, .fifo_in, .d2h_load, .sdb_load, .update_err_sts,
        .clear_bsy_drq, .set_bsy, .set_sts_7f, .set_sts_80,
        .tfd, .tfd_wb, .fis_i, .sdb_n
    );

    hba_reg_wr u_reg_wr (
        .mclk, .hba_rst, .fifo_in, .store, .store_addr, .sig_hi, .sig_lo,
        .tfd, .tfd_wb, .reg_wr
    );

endmodule

`default_nettype wire

// File: fis_receive_props.sv
`timescale 1ns/1ps
`default_nettype none

module fis_receive_props (
    input wire logic mclk,
    input wire logic hba_rst,
    input wire logic get_fis_done,
    input wire logic fis_ok,
    input wire logic fis_err,
    input wire logic fis_ferr
);

    done_single: assert property (@(posedge mclk) disable iff (hba_rst)
        get_fis_done |=> !get_fis_done)
        else $error("get_fis_done held for more than one cycle");

    ok_err_excl: assert property (@(posedge mclk) disable iff (hba_rst)
        !(fis_ok && fis_err))
        else $error("fis_ok and fis_err high together");

    ferr_sticky: assert property (@(posedge mclk) disable iff (hba_rst)
        fis_ferr |=> fis_ferr)
        else $error("fis_ferr dropped without reset");

endmodule

`default_nettype wire

// File: tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic mclk,
    output logic rst    // power-on reset, three cycles
);

    initial begin
        mclk = 1'b0;
        forever #20 mclk = ~mclk;   // 40 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (3) @(posedge mclk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

// File: tb_fis_receive.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fis_receive
    import fis_rx_pkg::*;
    import hba_regs_pkg::*;
;

    localparam int TMO = 400;           // cycles per wait

    logic mclk, rst_gen, tb_rst, hba_rst;
    fifo_in_t  fifo_in;
    logic      hba_data_in_ready;
    fis_sel_t  get;
    logic      fis_first_vld, get_fis_busy, get_fis_done, fis_ok, fis_err, fis_ferr;
    logic      update_err_sts, clear_bsy_drq, set_bsy, set_sts_7f, set_sts_80;
    tfd_t      tfd;
    logic      fis_i, sdb_n;
    dw_count_t data_in_dwords;
    logic      dma_in_ready, dma_in_valid;
    reg_wr_t   reg_wr;

    logic [31:0] vec [0:511];           // record stream from the vector file
    logic [33:0] fifo_q [$];            // {tag, data} waiting in the fifo model
    reg_wr_t     wr_q [$];
    dword_t      dma_q [$];
    logic [1:0]  pop_hist;              // pops seen in the last two cycles
    bit          rand_bp;               // random dma back-pressure on
    bit          timed_out;
    int          errors;

    assign hba_rst = rst_gen || tb_rst;

    tb_clk_gen u_clk (.mclk(mclk), .rst(rst_gen));

    fis_receive u_fis_receive (.*);

    bind fis_receive fis_receive_props u_props (
        .mclk(mclk), .hba_rst(hba_rst), .get_fis_done(get_fis_done),
        .fis_ok(fis_ok), .fis_err(fis_err), .fis_ferr(fis_ferr)
    );

    // fifo model, pops on the sampled ready
    always @(posedge mclk) begin
        logic [33:0] head_w;
        if (hba_rst) begin
            fifo_q.delete();
        end else if (hba_data_in_ready) begin
            if (!fifo_in.valid || (!fifo_in.many && pop_hist != 2'b00)) begin
                errors++;
                $display("Fail %0t: pop while the fifo word may not be taken", $time);
            end
            if (fifo_q.size() > 0) void'(fifo_q.pop_front());
        end
        pop_hist <= hba_rst ? 2'b00 : {pop_hist[0], hba_data_in_ready};
        head_w = (fifo_q.size() > 0) ? fifo_q[0] : '0;
        fifo_in <= '{data: head_w[31:0], dtype: head_w[33:32],
                     valid: fifo_q.size() > 0, many: fifo_q.size() > 1};
    end

    // dma back-pressure, ready low about one cycle in four
    initial begin
        void'($urandom(32'hf3dfd041));
        dma_in_ready = 1'b1;
        forever begin
            @(posedge mclk);
            dma_in_ready <= rand_bp ? (($urandom % 4) != 0) : 1'b1;
        end
    end

    always @(posedge mclk) begin
        if (reg_wr.we) wr_q.push_back(reg_wr);
        if (dma_in_valid) dma_q.push_back(fifo_in.data);   // word leaves the fifo
    end

    task automatic check_reg(input reg_wr_t got, input reg_wr_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("Fail %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_tfd(input tfd_t got, input tfd_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("Fail %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input dw_count_t got, input dw_count_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("Fail %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_word(input dword_t got, input dword_t exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("Fail %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("Fail %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    function automatic bit cond_met(input int which);
        case (which)
            0:       return fis_first_vld;
            1:       return get_fis_done;
            default: return wr_q.size() > 0;
        endcase
    endfunction

    task automatic wait_for(input int which, input string what);
        int n;
        n = 0;
        while (!timed_out) begin
            @(posedge mclk);
            if (cond_met(which)) break;
            n++;
            if (n > TMO) begin
                timed_out = 1'b1;
                $display("timeout while waiting for %s", what);
            end
        end
    endtask

    function automatic fis_sel_t sel_of(input int kind);
        fis_sel_t s;
        s = '0;
        case (kind)
            1: s.rfis     = 1'b1;
            2: s.psfis    = 1'b1;
            3: s.data_fis = 1'b1;
            4: s.sig      = 1'b1;
            default: s.ufis = 1'b1;
        endcase
        return s;
    endfunction

    function automatic reg_addr_t slot_of(input int kind);
        case (kind)
            1:       return FB_ADDR + RFIS_OFFS;
            2:       return FB_ADDR + PSFIS_OFFS;
            default: return FB_ADDR + UFIS_OFFS;
        endcase
    endfunction

    initial begin
        int p, kind, ndw, nst;
        logic [31:0] hdr, exp0, exp1;
        reg_wr_t exp_wr;
        get = '0;
        fifo_in = '0;
        tb_rst = 1'b0;
        {update_err_sts, clear_bsy_drq, set_bsy, set_sts_7f, set_sts_80} = '0;
        rand_bp = 1'b0;
        timed_out = 1'b0;
        errors = 0;
        $readmemh("fis_vectors.txt", vec);
        repeat (5) @(posedge mclk);     // past the power-on reset
        p = 0;
        while (!timed_out && (vec[p][31:24] >= 8'd1) && (vec[p][31:24] <= 8'd6)) begin
            hdr  = vec[p];
            exp0 = vec[p+1];
            exp1 = vec[p+2];
            kind = hdr[31:24];
            ndw  = hdr[23:16];
            wr_q.delete();
            dma_q.delete();
            if (kind == 5) begin        // tfd command in the first data word
                set_bsy        <= vec[p+3][0];
                clear_bsy_drq  <= vec[p+3][1];
                set_sts_7f     <= vec[p+3][2];
                set_sts_80     <= vec[p+3][2];
                update_err_sts <= vec[p+3][3];
                @(posedge mclk);
                {update_err_sts, clear_bsy_drq, set_bsy, set_sts_7f, set_sts_80} <= '0;
                wait_for(2, "PxTFD write");
                if (!timed_out) begin
                    check_tfd(tfd, exp0[15:0], "tfd after command");
                    exp_wr = '{we: 1'b1, addr: PXTFD_ADDR, data: {16'h0, exp0[15:0]}};
                    check_reg(wr_q[0], exp_wr, "PxTFD write");
                end
            end else begin
                rand_bp = (kind == 3);
                for (int i = 0; i < ndw; i++) begin
                    fifo_q.push_back({(i == 0) ? DATA_TYPE_FIS_HEAD : DATA_TYPE_DMA, vec[p+3+i]});
                end
                fifo_q.push_back({hdr[9:8], 32'h0});     // end word
                wait_for(0, "FIS head");
                get <= sel_of(kind);
                @(posedge mclk);
                get <= '0;
                @(posedge mclk);
                check_flag(get_fis_busy, 1'b1, "get_fis_busy after get");
                check_flag(fis_first_vld, 1'b0, "fis_first_vld after get");
                wait_for(1, "get_fis_done");
                if (!timed_out) begin
                    check_flag(get_fis_busy, 1'b0, "get_fis_busy after done");
                    check_flag(fis_ok, hdr[0], "fis_ok");
                    check_flag(fis_err, hdr[1], "fis_err");
                    check_flag(fis_ferr, hdr[2], "fis_ferr");
                    check_flag(sdb_n, 1'b0, "sdb_n without set device bits FIS");
                    if (kind == 1 || kind == 2 || kind == 6) begin
                        nst = (kind == 6) ? 16 : ndw;
                        check_count(dw_count_t'(wr_q.size()), dw_count_t'(nst), "stored words");
                        for (int i = 0; i < nst && i < wr_q.size(); i++) begin
                            exp_wr = '{we: 1'b1, addr: reg_addr_t'(slot_of(kind) + i),
                                       data: vec[p+3+i]};
                            check_reg(wr_q[i], exp_wr, "stored FIS word");
                        end
                    end
                    if (kind == 1 || kind == 4) check_tfd(tfd, exp0[15:0], "tfd from DWORD 0");
                    if (kind == 1) check_flag(fis_i, exp1[0], "fis_i");
                    if (kind == 3) begin
                        check_count(data_in_dwords, exp0[11:0], "data_in_dwords");
                        check_count(dw_count_t'(dma_q.size()), dw_count_t'(ndw - 1), "dma words");
                        check_count(dw_count_t'(wr_q.size()), '0, "register writes");
                        for (int i = 0; i < dma_q.size() && i < ndw - 1; i++) begin
                            check_word(dma_q[i], vec[p+4+i], "dma payload");
                        end
                    end
                    if (kind == 4) begin
                        check_count(dw_count_t'(wr_q.size()), 12'd1, "PxSIG writes");
                        exp_wr = '{we: 1'b1, addr: PXSIG_ADDR, data: exp1};
                        if (wr_q.size() > 0) check_reg(wr_q[0], exp_wr, "PxSIG write");
                    end
                    if (kind == 6) begin
                        repeat (4) @(posedge mclk);
                        check_flag(fis_ferr, 1'b1, "fis_ferr held");
                        tb_rst <= 1'b1;
                        repeat (3) @(posedge mclk);
                        tb_rst <= 1'b0;
                        @(posedge mclk);
                        check_flag(fis_ferr, 1'b0, "fis_ferr after reset");
                    end
                end
                rand_bp = 1'b0;
            end
            p = p + 3 + ndw;
        end
        $display("run done: %0d value errors, %0d timeouts", errors, timed_out);
        if (errors == 0 && !timed_out) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: fis_vectors.txt
// record: hdr exp0 exp1 then ndw dwords; hdr = kind[31:24] ndw[23:16] end_tag[15:8] flags[2:0]
// kinds 1 rfis 2 psfis 3 data 4 sig 5 tfd cmd 6 ufis overrun; flags = {ferr, err, ok}
01050201 00004150 00000001
12344150 a1a2a3a4 b1b2b3b4 c1c2c3c4 d1d2d3d4
02050302 00000000 00000000
5f00a0b1 11111111 22222222 33333333 44444444
03070201 00000006 00000000
00000046 d0000001 d0000002 d0000003 d0000004 d0000005 d0000006
04050201 00000150 eb140101
00000150 00eb1401 00000000 00000001 00000000
05010000 000001d0 00000000 00000001
05010000 00000150 00000000 00000002
05010000 000001ff 00000000 00000004
05010000 000001ff 00000000 00000008
06110204 00000000 00000000
00000039 e0000001 e0000002 e0000003 e0000004 e0000005 e0000006 e0000007
e0000008 e0000009 e000000a e000000b e000000c e000000d e000000e e000000f
e0000010
00000000

// File: tb.f
fis_rx_pkg.sv
hba_regs_pkg.sv
fis_rx_ctrl.sv
fis_dma_fwd.sv
tfd_status.sv
hba_reg_wr.sv
fis_receive.sv
fis_receive_props.sv
tb_clk_gen.sv
tb_fis_receive.sv

// File: Bender.yml
package:
  name: fis_receive

sources:
  - fis_rx_pkg.sv
  - hba_regs_pkg.sv
  - fis_rx_ctrl.sv
  - fis_dma_fwd.sv
  - tfd_status.sv
  - hba_reg_wr.sv
  - fis_receive.sv
  - target: test
    files:
      - fis_receive_props.sv
      - tb_clk_gen.sv
      - tb_fis_receive.sv
